//--- include/ll_settings.svh
`ifndef LL_SETTINGS_SVH
`define LL_SETTINGS_SVH

// Both short FIFOs hold 2**FIFO_DEPTH_LOG2 entries
`define FIFO_DEPTH_LOG2 4

// Flag positions in the packed 19-bit word
`define F19_OCC_BIT 18
`define F19_EOF_BIT 17
`define F19_SOF_BIT 16

`endif

//--- rtl/ll_types_pkg.sv
package ll_types_pkg;

   // One byte of the link-layer stream
   typedef logic [7:0] ll_byte_t;

   // Byte with its frame flags as held in the input FIFO
   // Layout is {eof, sof, byte}
   typedef logic [9:0] ll_entry_t;

   localparam int LL_ENTRY_EOF_BIT = 9;
   localparam int LL_ENTRY_SOF_BIT = 8;

endpackage

//--- rtl/f19_types_pkg.sv
package f19_types_pkg;

   // Packed output word
   // {occ, eof, sof, first byte, second byte}
   typedef logic [18:0] f19_word_t;

   // Packer states
   typedef enum logic [1:0] {
      PACK_EMPTY      = 2'd0,
      PACK_HALF       = 2'd1,
      PACK_HALF_WRITE = 2'd3
   } pack_state_t;

endpackage

//--- rtl/fifo_short.sv
`timescale 1ns/1ps

`include "ll_settings.svh"

module fifo_short #(
   parameter int WIDTH      = 19,
   parameter int DEPTH_LOG2 = `FIFO_DEPTH_LOG2
) (
   input  logic             clk,
   input  logic             arst_n_i,
   input  logic             clear_i,

   input  logic [WIDTH-1:0] data_i,
   input  logic             src_rdy_i,
   output logic             dst_rdy_o,

   output logic [WIDTH-1:0] data_o,
   output logic             src_rdy_o,
   input  logic             dst_rdy_i
);

   localparam int DEPTH = 1 << DEPTH_LOG2;

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   // One bit wider than the pointers so full and empty differ
   logic [DEPTH_LOG2:0]   count;
   logic                  push;
   logic                  pop;

   // Ready on the input side only looks at our own fill level
   assign dst_rdy_o = ~count[DEPTH_LOG2];
   assign src_rdy_o = (count != '0);
   assign data_o    = mem[rd_ptr];

   assign push = src_rdy_i & dst_rdy_o;
   assign pop  = src_rdy_o & dst_rdy_i;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= data_i;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_count_in_range: assert property (
      @(posedge clk) disable iff (!arst_n_i)
      count <= DEPTH
   );

   // Head entry must hold until the reader takes it
   a_hold_while_stalled: assert property (
      @(posedge clk) disable iff (!arst_n_i)
      (src_rdy_o && !dst_rdy_i && !clear_i) |=> (src_rdy_o && $stable(data_o))
   );

endmodule

//--- rtl/ll8_pack_core.sv
`timescale 1ns/1ps

`include "ll_settings.svh"

module ll8_pack_core (
   input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic                      clear_i,

   input  ll_types_pkg::ll_entry_t   in_entry_i,
   input  logic                      in_src_rdy_i,
   output logic                      in_dst_rdy_o,

   output f19_types_pkg::f19_word_t  out_word_o,
   output logic                      out_src_rdy_o,
   input  logic                      out_dst_rdy_i
);

   import ll_types_pkg::*;
   import f19_types_pkg::*;

   pack_state_t state;
   ll_byte_t    in_byte;
   logic        in_sof;
   logic        in_eof;
   ll_byte_t    hold_byte;
   logic        hold_sof;
   logic        load_first;

   assign in_byte = in_entry_i[7:0];
   assign in_sof  = in_entry_i[LL_ENTRY_SOF_BIT];
   assign in_eof  = in_entry_i[LL_ENTRY_EOF_BIT];

   // In PACK_EMPTY every offered byte is taken
   assign load_first = (state == PACK_EMPTY) & in_src_rdy_i;

   always_ff @(posedge clk) begin
      if (load_first) begin
         hold_byte <= in_byte;
         hold_sof  <= in_sof;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state <= PACK_EMPTY;
      end else if (clear_i) begin
         state <= PACK_EMPTY;
      end else begin
         case (state)
            PACK_EMPTY: begin
               if (in_src_rdy_i) begin
                  state <= in_eof ? PACK_HALF_WRITE : PACK_HALF;
               end
            end
            PACK_HALF: begin
               // Second byte and the word move on the same edge
               if (in_src_rdy_i && out_dst_rdy_i) begin
                  state <= PACK_EMPTY;
               end
            end
            PACK_HALF_WRITE: begin
               if (out_dst_rdy_i) begin
                  state <= PACK_EMPTY;
               end
            end
            default: state <= PACK_EMPTY;
         endcase
      end
   end

   assign in_dst_rdy_o  = (state == PACK_EMPTY) |
                          ((state == PACK_HALF) & out_dst_rdy_i);
   assign out_src_rdy_o = (state == PACK_HALF_WRITE) |
                          ((state == PACK_HALF) & in_src_rdy_i);

   always_comb begin
      out_word_o                 = '0;
      out_word_o[`F19_OCC_BIT]   = (state == PACK_HALF_WRITE);
      out_word_o[`F19_EOF_BIT]   = (state == PACK_HALF_WRITE) |
                                   ((state == PACK_HALF) & in_eof);
      out_word_o[`F19_SOF_BIT]   = hold_sof;
      out_word_o[15:8]           = hold_byte;
      // Don't care for an occupied word
      out_word_o[7:0]            = in_byte;
   end

   a_state_legal: assert property (
      @(posedge clk) disable iff (!arst_n_i)
      state inside {PACK_EMPTY, PACK_HALF, PACK_HALF_WRITE}
   );

endmodule

//--- rtl/ll8_to_fifo19.sv
`timescale 1ns/1ps

`include "ll_settings.svh"

module ll8_to_fifo19 (
   input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic                      clear_i,

   input  ll_types_pkg::ll_byte_t    ll_data_i,
   input  logic                      ll_sof_i,
   input  logic                      ll_eof_i,
   input  logic                      ll_src_rdy_i,
   output logic                      ll_dst_rdy_o,

   output f19_types_pkg::f19_word_t  f19_data_o,
   output logic                      f19_src_rdy_o,
   input  logic                      f19_dst_rdy_i
);

   import ll_types_pkg::*;
   import f19_types_pkg::*;

   ll_entry_t in_entry;
   logic      in_src_rdy;
   logic      in_dst_rdy;
   f19_word_t pack_word;
   logic      pack_src_rdy;
   logic      pack_dst_rdy;

   // Head FIFO keeps the packer's ready path off the input port
   fifo_short #(
      .WIDTH      ($bits(ll_entry_t)),
      .DEPTH_LOG2 (`FIFO_DEPTH_LOG2)
   ) u_head_fifo (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .clear_i    (clear_i),
      .data_i     ({ll_eof_i, ll_sof_i, ll_data_i}),
      .src_rdy_i  (ll_src_rdy_i),
      .dst_rdy_o  (ll_dst_rdy_o),
      .data_o     (in_entry),
      .src_rdy_o  (in_src_rdy),
      .dst_rdy_i  (in_dst_rdy)
   );

   ll8_pack_core u_pack (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .clear_i        (clear_i),
      .in_entry_i     (in_entry),
      .in_src_rdy_i   (in_src_rdy),
      .in_dst_rdy_o   (in_dst_rdy),
      .out_word_o     (pack_word),
      .out_src_rdy_o  (pack_src_rdy),
      .out_dst_rdy_i  (pack_dst_rdy)
   );

   // Tail FIFO keeps the output port off the packer's ready path
   fifo_short #(
      .WIDTH      ($bits(f19_word_t)),
      .DEPTH_LOG2 (`FIFO_DEPTH_LOG2)
   ) u_tail_fifo (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .clear_i    (clear_i),
      .data_i     (pack_word),
      .src_rdy_i  (pack_src_rdy),
      .dst_rdy_o  (pack_dst_rdy),
      .data_o     (f19_data_o),
      .src_rdy_o  (f19_src_rdy_o),
      .dst_rdy_i  (f19_dst_rdy_i)
   );

endmodule

//--- tb/tb_ll8_to_fifo19.sv
`timescale 1ns/1ps

`include "ll_settings.svh"

module tb_ll8_to_fifo19;

   import ll_types_pkg::*;
   import f19_types_pkg::*;

   typedef ll_byte_t byte_queue_t[$];

   localparam int          DEPTH       = 1 << `FIFO_DEPTH_LOG2;
   localparam int          STALL_LEN   = 8 * DEPTH;
   localparam int          WAIT_LIMIT  = 1000;
   localparam int          DRAIN_LIMIT = 4000;
   localparam logic [15:0] LFSR_SEED   = 16'd58;
   localparam logic [15:0] LFSR_TAPS   = 16'hB400;
   localparam int          SINK_READY  = 0;
   localparam int          SINK_HOLD   = 1;
   localparam int          SINK_RANDOM = 2;

   logic      clk = 1'b0;
   logic      arst_n_i;
   logic      clear_i;
   ll_byte_t  ll_data_i;
   logic      ll_sof_i;
   logic      ll_eof_i;
   logic      ll_src_rdy_i;
   logic      ll_dst_rdy_o;
   f19_word_t f19_data_o;
   logic      f19_src_rdy_o;
   logic      f19_dst_rdy_i;

   f19_word_t   exp_q[$];
   logic [15:0] src_lfsr  = LFSR_SEED;
   logic [15:0] sink_lfsr = LFSR_SEED;
   int          sink_mode = SINK_READY;
   int          word_checks = 0;
   int          word_errors = 0;
   int          main_checks = 0;
   int          main_errors = 0;
   int          in_full_cycles = 0;
   int          tests_done = 0;

   ll8_to_fifo19 dut (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .clear_i       (clear_i),
      .ll_data_i     (ll_data_i),
      .ll_sof_i      (ll_sof_i),
      .ll_eof_i      (ll_eof_i),
      .ll_src_rdy_i  (ll_src_rdy_i),
      .ll_dst_rdy_o  (ll_dst_rdy_o),
      .f19_data_o    (f19_data_o),
      .f19_src_rdy_o (f19_src_rdy_o),
      .f19_dst_rdy_i (f19_dst_rdy_i)
   );

   always #20 clk = ~clk;

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ LFSR_TAPS;
      end
      return n;
   endfunction

   function automatic logic [31:0] rand_src(input int nbits);
      logic [31:0] v;
      int          k;
      v = '0;
      for (k = 0; k < nbits; k++) begin
         src_lfsr = lfsr_next(src_lfsr);
         v = {v[30:0], src_lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [31:0] rand_sink(input int nbits);
      logic [31:0] v;
      int          k;
      v = '0;
      for (k = 0; k < nbits; k++) begin
         sink_lfsr = lfsr_next(sink_lfsr);
         v = {v[30:0], sink_lfsr[0]};
      end
      return v;
   endfunction

   // Two bytes per word, first byte on top, odd tail goes out as an occupied word
   function automatic void ref_pack(input byte_queue_t frame);
      f19_word_t w;
      int        i;
      for (i = 0; i < frame.size(); i += 2) begin
         w = '0;
         w[`F19_SOF_BIT] = (i == 0);
         w[15:8] = frame[i];
         if (i + 1 < frame.size()) begin
            w[7:0] = frame[i + 1];
            w[`F19_EOF_BIT] = (i + 2 >= frame.size());
         end else begin
            w[`F19_OCC_BIT] = 1'b1;
            w[`F19_EOF_BIT] = 1'b1;
         end
         exp_q.push_back(w);
      end
   endfunction

   function automatic int total_errors();
      return word_errors + main_errors;
   endfunction

   task automatic check_word(input string name, input f19_word_t exp, input f19_word_t act);
      f19_word_t mask;
      mask = '1;
      // Lower byte of an occupied word carries nothing
      if (exp[`F19_OCC_BIT]) begin
         mask[7:0] = '0;
      end
      word_checks++;
      if (((exp ^ act) & mask) !== '0) begin
         $display("FAILED %s expected %h got %h", name, exp, act);
         word_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      main_checks++;
      if (exp !== act) begin
         $display("FAILED %s expected %h got %h", name, exp, act);
         main_errors++;
      end
   endtask

   task automatic timeout_abort(input string what);
      $display("Timed out: %s", what);
      $display("ERRORS FOUND");
      $finish;
   endtask

   task automatic step_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic send_byte(input ll_byte_t b, input logic sof, input logic eof);
      int waited;
      waited = 0;
      ll_data_i    = b;
      ll_sof_i     = sof;
      ll_eof_i     = eof;
      ll_src_rdy_i = 1'b1;
      @(negedge clk);
      while (!ll_dst_rdy_o) begin
         waited++;
         if (waited > WAIT_LIMIT) begin
            timeout_abort("input side never became ready");
         end
         @(negedge clk);
      end
      @(posedge clk);
      #2;
      ll_src_rdy_i = 1'b0;
   endtask

   task automatic send_frame(input int len, input logic gaps);
      byte_queue_t frame;
      int          i;
      frame = {};
      for (i = 0; i < len; i++) begin
         frame.push_back(ll_byte_t'(rand_src(8)));
      end
      ref_pack(frame);
      for (i = 0; i < len; i++) begin
         send_byte(frame[i], (i == 0), (i == len - 1));
         if (gaps && rand_src(2) == 3) begin
            step_cycles(1 + int'(rand_src(2)));
         end
      end
   endtask

   task automatic wait_drain(input string what);
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         step_cycles(1);
         waited++;
         if (waited > DRAIN_LIMIT) begin
            timeout_abort({what, " left words undelivered"});
         end
      end
      step_cycles(4);
      check_bit("f19_src_rdy_o", 1'b0, f19_src_rdy_o);
   endtask

   task automatic report_test(input int num, input string name, input int err_before);
      tests_done++;
      $display("Test %0d %s: %0d errors", num, name, total_errors() - err_before);
   endtask

   // Sink side with the long stall at the start of random mode
   initial begin
      int stall_left;
      int prev_mode;
      stall_left    = 0;
      prev_mode     = SINK_READY;
      f19_dst_rdy_i = 1'b0;
      forever begin
         @(posedge clk);
         #2;
         if (sink_mode == SINK_RANDOM && prev_mode != SINK_RANDOM) begin
            stall_left = STALL_LEN;
         end
         prev_mode = sink_mode;
         if (sink_mode == SINK_READY) begin
            f19_dst_rdy_i = 1'b1;
         end else if (sink_mode == SINK_HOLD) begin
            f19_dst_rdy_i = 1'b0;
         end else if (stall_left > 0) begin
            f19_dst_rdy_i = 1'b0;
            stall_left--;
         end else if (rand_sink(4) == 0) begin
            f19_dst_rdy_i = 1'b0;
            stall_left = 2 * DEPTH;
         end else begin
            f19_dst_rdy_i = (rand_sink(2) != 0);
         end
      end
   end

   // Handshake levels are settled at the falling edge
   always @(negedge clk) begin
      if (arst_n_i && !ll_dst_rdy_o) begin
         in_full_cycles++;
      end
      if (arst_n_i && !clear_i && f19_src_rdy_o && f19_dst_rdy_i) begin
         if (exp_q.size() == 0) begin
            $display("Output word %h arrived with no word expected", f19_data_o);
            word_errors++;
         end else begin
            check_word("f19_data_o", exp_q.pop_front(), f19_data_o);
         end
      end
   end

   initial begin
      int err_before;
      int full_before;
      int n;
      arst_n_i     = 1'b0;
      clear_i      = 1'b0;
      ll_data_i    = '0;
      ll_sof_i     = 1'b0;
      ll_eof_i     = 1'b0;
      ll_src_rdy_i = 1'b0;
      repeat (3) @(posedge clk);
      #2;
      arst_n_i = 1'b1;

      err_before = total_errors();
      check_bit("f19_src_rdy_o", 1'b0, f19_src_rdy_o);
      check_bit("ll_dst_rdy_o", 1'b1, ll_dst_rdy_o);
      report_test(1, "reset levels", err_before);

      err_before = total_errors();
      for (n = 2; n <= 8; n += 2) begin
         send_frame(n, 1'b0);
      end
      wait_drain("even frames");
      report_test(2, "even frames", err_before);

      err_before = total_errors();
      for (n = 1; n <= 9; n += 2) begin
         send_frame(n, 1'b0);
      end
      send_frame(1, 1'b0);
      wait_drain("odd frames");
      report_test(3, "odd frames", err_before);

      err_before  = total_errors();
      full_before = in_full_cycles;
      sink_mode   = SINK_RANDOM;
      repeat (40) begin
         send_frame(1 + int'(rand_src(4)) % 9, 1'b1);
      end
      wait_drain("random frames");
      if (in_full_cycles == full_before) begin
         $display("Input side never showed back-pressure during the sink stalls");
         main_errors++;
      end
      report_test(4, "random frames with back-pressure", err_before);

      err_before = total_errors();
      sink_mode  = SINK_HOLD;
      step_cycles(2);
      // Partial frame that never ends and backs up into the input FIFO
      for (n = 0; n < 3 * DEPTH + 1; n++) begin
         send_byte(ll_byte_t'(n), (n == 0), 1'b0);
      end
      step_cycles(4);
      check_bit("f19_src_rdy_o", 1'b1, f19_src_rdy_o);
      check_bit("ll_dst_rdy_o", 1'b0, ll_dst_rdy_o);
      clear_i = 1'b1;
      step_cycles(1);
      clear_i = 1'b0;
      check_bit("f19_src_rdy_o", 1'b0, f19_src_rdy_o);
      check_bit("ll_dst_rdy_o", 1'b1, ll_dst_rdy_o);
      sink_mode = SINK_READY;
      send_frame(5, 1'b0);
      send_frame(4, 1'b0);
      wait_drain("frames after clear");
      report_test(5, "clear mid-frame", err_before);

      $display("Tests %0d, checks %0d, errors %0d", tests_done,
               word_checks + main_checks, total_errors());
      if (total_errors() == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

//--- list.f
+incdir+include
rtl/ll_types_pkg.sv
rtl/f19_types_pkg.sv
rtl/fifo_short.sv
rtl/ll8_pack_core.sv
rtl/ll8_to_fifo19.sv
tb/tb_ll8_to_fifo19.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_ll8_to_fifo19 \
   -Mdir obj_dir -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
if grep -q "ERRORS FOUND" sim.log; then
   echo "Simulation reported failures"
   exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
   echo "Simulation ended without a result line"
   exit 1
fi
echo "Simulation passed"
